// File: build.f
+incdir+source
source/apbI2cPkg.sv
source/apbRegs.sv
source/syncFifo.sv
source/i2cMaster.sv
source/apbI2cTop.sv
testbench/tbClock.sv
testbench/i2cSlaveModel.sv
testbench/apbI2cTb.sv

// File: run.sh
#!/bin/sh
# Build and run the APB I2C testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module apbI2cTb -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if echo "$output" | grep -q "Simulation PASSED"; then
	exit 0
fi
exit 1

// File: source/apbI2cPkg.sv
`default_nettype none

package apbI2cPkg;

	// One byte on the I2C wire
	typedef logic [7:0] dataByte;

	// APB address and data bus
	typedef logic [31:0] apbWord;

	// Width of the config and timeout registers
	typedef logic [13:0] regField;

	// 7-bit I2C slave address
	typedef logic [6:0] slaveAddr;

	// Number of bytes in a read transfer
	typedef logic [4:0] byteCount;

	// Byte engine states, in bus order
	typedef enum logic [3:0]
	{
		Idle,
		Start,
		AddrSend,
		AddrAck,
		WriteByte,
		WriteAck,
		ReadByte,
		ReadAck,
		Stop
	} masterState;

endpackage

`default_nettype wire

// File: source/apbI2cTop.sv
`timescale 1ns/10ps
`default_nettype none

`include "apbI2c_defines.svh"

module apbI2cTop
(
	// APB slave port
	input  wire                    PCLK,
	input  wire                    PRESETn,
	input  wire                    PSEL,
	input  wire                    PENABLE,
	input  wire                    PWRITE,
	input  wire apbI2cPkg::apbWord PADDR,
	input  wire apbI2cPkg::apbWord PWDATA,
	output apbI2cPkg::apbWord      PRDATA,
	output logic                   PREADY,
	output logic                   PSLVERR,
	// Interrupts
	output logic                   intTx,
	output logic                   intRx,
	// I2C open-drain pins
	output logic                   sclLow,
	output logic                   sdaLow,
	input  wire                    sclIn,
	input  wire                    sdaIn
);

	// Transmit path
	logic               txPushValid;
	apbI2cPkg::dataByte txPushData;
	logic               txPushReady;
	logic               txPopValid;
	apbI2cPkg::dataByte txPopData;
	logic               txPopReady;
	logic               txEmpty;

	// Receive path
	logic               rxPushValid;
	apbI2cPkg::dataByte rxPushData;
	logic               rxPushReady;
	logic               rxPopValid;
	apbI2cPkg::dataByte rxPopData;
	logic               rxPopReady;
	logic               rxEmpty;

	// Register block to master
	apbI2cPkg::slaveAddr cfgAddr;
	logic                cfgRead;
	logic                cfgEnable;
	apbI2cPkg::byteCount cfgCount;
	apbI2cPkg::regField  timeoutLimit;
	logic                cfgWrite;
	logic                doneClear;
	logic                error;

	// TX empty asks for data, RX non-empty offers data
	assign intTx = txEmpty;
	assign intRx = !rxEmpty;

	apbRegs regs
	(
		.PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
		.PRDATA, .PREADY, .PSLVERR,
		.txPushValid, .txPushData, .txPushReady,
		.rxPopReady, .rxPopValid, .rxPopData,
		.cfgAddr, .cfgRead, .cfgEnable, .cfgCount, .timeoutLimit, .cfgWrite,
		.doneClear, .error
	);

	syncFifo #(.Depth(`FifoDepth)) txFifo
	(
		.PCLK, .PRESETn,
		.pushValid (txPushValid),
		.pushData  (txPushData),
		.pushReady (txPushReady),
		.popReady  (txPopReady),
		.popValid  (txPopValid),
		.popData   (txPopData),
		.empty     (txEmpty)
	);

	syncFifo #(.Depth(`FifoDepth)) rxFifo
	(
		.PCLK, .PRESETn,
		.pushValid (rxPushValid),
		.pushData  (rxPushData),
		.pushReady (rxPushReady),
		.popReady  (rxPopReady),
		.popValid  (rxPopValid),
		.popData   (rxPopData),
		.empty     (rxEmpty)
	);

	i2cMaster master
	(
		.PCLK, .PRESETn,
		.cfgAddr, .cfgRead, .cfgEnable, .cfgCount, .timeoutLimit, .cfgWrite,
		.txPopValid, .txPopData, .txPopReady,
		.rxPushValid, .rxPushData, .rxPushReady,
		.busy(), .error, .doneClear,
		.sclLow, .sdaLow, .sclIn, .sdaIn
	);

endmodule

`default_nettype wire

// File: source/apbI2c_defines.svh
`ifndef APBI2C_DEFINES_SVH
`define APBI2C_DEFINES_SVH

//////////////////////////////////////////////////////////////
// APB register map (byte offsets)
//////////////////////////////////////////////////////////////

// Write pushes a byte into the transmit FIFO
`define AddrTx      32'h0000_0000
// Read pops a byte from the receive FIFO
`define AddrRx      32'h0000_0004
// Slave address, direction, enable and read count
`define AddrConfig  32'h0000_0008
// Abort limit in units of 16 PCLK cycles
`define AddrTimeout 32'h0000_000C

// Entries in each FIFO
`define FifoDepth   8

// PCLK cycles per SCL half period
`define SclHalf     4

`endif

// File: source/apbRegs.sv
`timescale 1ns/10ps
`default_nettype none

`include "apbI2c_defines.svh"

module apbRegs
(
	// APB slave port
	input  wire                    PCLK,
	input  wire                    PRESETn,
	input  wire                    PSEL,
	input  wire                    PENABLE,
	input  wire                    PWRITE,
	input  wire apbI2cPkg::apbWord PADDR,
	input  wire apbI2cPkg::apbWord PWDATA,
	output apbI2cPkg::apbWord      PRDATA,
	output logic                   PREADY,
	output logic                   PSLVERR,
	// Transmit FIFO push side
	output logic                   txPushValid,
	output apbI2cPkg::dataByte     txPushData,
	input  wire                    txPushReady,
	// Receive FIFO pop side
	output logic                   rxPopReady,
	input  wire                    rxPopValid,
	input  wire apbI2cPkg::dataByte rxPopData,
	// Transfer setup towards the master
	output apbI2cPkg::slaveAddr    cfgAddr,
	output logic                   cfgRead,
	output logic                   cfgEnable,
	output apbI2cPkg::byteCount    cfgCount,
	output apbI2cPkg::regField     timeoutLimit,
	output logic                   cfgWrite,
	// Status back from the master
	input  wire                    doneClear,
	input  wire                    error
);

	localparam int RegW = $bits(apbI2cPkg::regField);

	// Access phase of any transfer
	logic access;
	// Access phase aimed at the transmit FIFO
	logic txWrite;
	// Access phase aimed at the receive FIFO
	logic rxRead;
	// Completing writes to the two registers
	logic configHit;
	logic timeoutHit;

	apbI2cPkg::regField configReg;
	apbI2cPkg::regField timeoutReg;

	//////////////////////////////////////////////////////////////
	// Access decode and handshake
	//////////////////////////////////////////////////////////////

	assign access  = PSEL && PENABLE;
	assign txWrite = access && PWRITE && (PADDR == `AddrTx);
	assign rxRead  = access && !PWRITE && (PADDR == `AddrRx);

	// Zero wait state, except a TX push stalls while the FIFO is full
	assign PREADY = access && (!txWrite || txPushReady);

	// Low byte of PWDATA goes into the FIFO
	assign txPushValid = txWrite;
	assign txPushData  = PWDATA[7:0];

	// An RX read always completes in its first access cycle
	assign rxPopReady = rxRead;

	// Sticky master error, or a read from an empty RX FIFO
	assign PSLVERR = PREADY && (error || (rxRead && !rxPopValid));

	assign configHit  = PREADY && PWRITE && (PADDR == `AddrConfig);
	assign timeoutHit = PREADY && PWRITE && (PADDR == `AddrTimeout);

	// Read mux, unmapped offsets read as zero
	always_comb
	begin
		PRDATA = '0;
		case (PADDR)
			`AddrRx:
			begin
				// Empty FIFO gives zero data
				if (rxPopValid)
					PRDATA = {24'h0, rxPopData};
			end
			`AddrConfig:  PRDATA = {{(32 - RegW){1'b0}}, configReg};
			`AddrTimeout: PRDATA = {{(32 - RegW){1'b0}}, timeoutReg};
			default:      PRDATA = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////
	// Configuration and timeout registers
	//////////////////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			configReg  <= '0;
			timeoutReg <= '0;
			cfgWrite   <= 1'b0;
		end
		else
		begin
			// Strobe lines up with the new register contents
			cfgWrite <= configHit;
			// A host write beats the end-of-transfer clear
			if (configHit)
				configReg <= PWDATA[RegW-1:0];
			else if (doneClear)
				configReg[8] <= 1'b0;
			if (timeoutHit)
				timeoutReg <= PWDATA[RegW-1:0];
		end
	end

	// Field split of the config register
	assign cfgAddr      = configReg[6:0];
	assign cfgRead      = configReg[7];
	assign cfgEnable    = configReg[8];
	assign cfgCount     = configReg[13:9];
	assign timeoutLimit = timeoutReg;

	// Bytes only enter the TX FIFO when it reports room
	assert property (@(posedge PCLK) disable iff (!PRESETn)
		(PREADY && txPushValid) |-> txPushReady);

	// An error response only on a completing cycle
	assert property (@(posedge PCLK) disable iff (!PRESETn)
		PSLVERR |-> PREADY);

endmodule

`default_nettype wire

// File: source/i2cMaster.sv
`timescale 1ns/10ps
`default_nettype none

`include "apbI2c_defines.svh"

module i2cMaster
(
	input  wire                      PCLK,
	input  wire                      PRESETn,
	// Transfer setup from the register block
	input  wire apbI2cPkg::slaveAddr cfgAddr,
	input  wire                      cfgRead,
	input  wire                      cfgEnable,
	input  wire apbI2cPkg::byteCount cfgCount,
	input  wire apbI2cPkg::regField  timeoutLimit,
	input  wire                      cfgWrite,
	// Transmit FIFO pop side
	input  wire                      txPopValid,
	input  wire apbI2cPkg::dataByte  txPopData,
	output logic                     txPopReady,
	// Receive FIFO push side
	output logic                     rxPushValid,
	output apbI2cPkg::dataByte       rxPushData,
	input  wire                      rxPushReady,
	// Status
	output logic                     busy,
	output logic                     error,
	output logic                     doneClear,
	// Open-drain bus, pull-low outputs and resolved inputs
	output logic                     sclLow,
	output logic                     sdaLow,
	input  wire                      sclIn,
	input  wire                      sdaIn
);

	// One bit is SCL low for SclHalf cycles, then high for SclHalf
	localparam int BitLen = 2 * `SclHalf;
	localparam int PhaseW = $clog2(BitLen);
	localparam int BusyW  = $bits(apbI2cPkg::regField) + 4;
	localparam logic [PhaseW-1:0] LastPhase = PhaseW'(BitLen - 1);
	localparam logic [PhaseW-1:0] HighStart = PhaseW'(`SclHalf);
	localparam logic [PhaseW-1:0] SdaFall   = PhaseW'(`SclHalf - 1);
	// Middle of SCL high
	localparam logic [PhaseW-1:0] SampleAt  = PhaseW'(`SclHalf + `SclHalf / 2);
	localparam logic [PhaseW-1:0] StopRise  = PhaseW'(`SclHalf + `SclHalf / 2 - 1);

	apbI2cPkg::masterState state;
	logic [PhaseW-1:0] phase;
	logic [2:0] bitCnt;
	apbI2cPkg::dataByte shiftReg;
	apbI2cPkg::byteCount bytesLeft;
	logic nackSeen;
	logic [BusyW-1:0] busyCnt;

	logic lastPhase;
	logic lastBit;
	logic startReq;
	logic hold;
	logic abort;
	logic moreToRead;
	logic loadTx;

	//////////////////////////////////////////////////////////////
	// Control decode
	//////////////////////////////////////////////////////////////

	assign lastPhase  = (phase == LastPhase);
	assign lastBit    = (bitCnt == 3'd7);
	assign moreToRead = (bytesLeft != '0);

	// Write needs a byte waiting, read just needs the enable
	assign startReq = (state == apbI2cPkg::Idle) && cfgEnable && (cfgRead || txPopValid);

	// Park with SCL low ahead of a read byte while the RX FIFO is full
	assign hold = (state == apbI2cPkg::ReadByte) && (bitCnt == 3'd0)
		&& (phase == '0) && !rxPushReady;

	// Limit is in units of 16 cycles, zero turns it off
	assign abort = (timeoutLimit != '0) && (busyCnt >= {timeoutLimit, 4'h0})
		&& (state != apbI2cPkg::Idle) && (state != apbI2cPkg::Stop);

	// Next write byte is fetched at the end of an ACKed ack slot
	assign loadTx = (((state == apbI2cPkg::AddrAck) && !cfgRead)
		|| (state == apbI2cPkg::WriteAck))
		&& lastPhase && !nackSeen && txPopValid && !abort;
	assign txPopReady = loadTx;

	// Received byte is complete after the last bit's high phase
	assign rxPushValid = (state == apbI2cPkg::ReadByte) && lastBit && lastPhase;
	assign rxPushData  = shiftReg;

	assign busy      = (state != apbI2cPkg::Idle);
	assign doneClear = (state == apbI2cPkg::Stop) && lastPhase;

	// SCL stays released through Idle and the START bit
	assign sclLow = (state != apbI2cPkg::Idle) && (state != apbI2cPkg::Start)
		&& (phase < HighStart);

	//////////////////////////////////////////////////////////////
	// Byte engine
	//////////////////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			state     <= apbI2cPkg::Idle;
			phase     <= '0;
			bitCnt    <= '0;
			bytesLeft <= '0;
			nackSeen  <= 1'b0;
			busyCnt   <= '0;
			sdaLow    <= 1'b0;
			error     <= 1'b0;
		end
		else
		begin
			busyCnt <= (state == apbI2cPkg::Idle) ? '0 : busyCnt + 1'b1;
			// New configuration clears the error, a fresh fault wins
			if (cfgWrite)
				error <= 1'b0;
			if (abort)
			begin
				// Timeout, finish with STOP
				state <= apbI2cPkg::Stop;
				phase <= '0;
				error <= 1'b1;
			end
			else
			begin
				if ((state != apbI2cPkg::Idle) && !hold)
					phase <= lastPhase ? '0 : phase + 1'b1;
				case (state)
					apbI2cPkg::Idle:
					begin
						sdaLow <= 1'b0;
						if (startReq)
						begin
							state     <= apbI2cPkg::Start;
							shiftReg  <= {cfgAddr, cfgRead};
							bytesLeft <= cfgCount;
							bitCnt    <= '0;
						end
					end
					apbI2cPkg::Start:
					begin
						// SDA falls in the middle with SCL high
						if (phase == SdaFall)
							sdaLow <= 1'b1;
						if (lastPhase)
							state <= apbI2cPkg::AddrSend;
					end
					apbI2cPkg::AddrSend, apbI2cPkg::WriteByte:
					begin
						// MSB first, driven one cycle after SCL falls
						if (phase == '0)
							sdaLow <= !shiftReg[7];
						if (lastPhase)
						begin
							shiftReg <= {shiftReg[6:0], 1'b0};
							bitCnt   <= bitCnt + 1'b1;
							if (lastBit)
								state <= (state == apbI2cPkg::AddrSend) ?
									apbI2cPkg::AddrAck : apbI2cPkg::WriteAck;
						end
					end
					apbI2cPkg::AddrAck, apbI2cPkg::WriteAck:
					begin
						// Release SDA for the slave's answer
						if (phase == '0)
							sdaLow <= 1'b0;
						if (phase == SampleAt)
							nackSeen <= sdaIn;
						if (lastPhase)
						begin
							if (nackSeen)
							begin
								error <= 1'b1;
								state <= apbI2cPkg::Stop;
							end
							else if (cfgRead && (state == apbI2cPkg::AddrAck))
								state <= moreToRead ? apbI2cPkg::ReadByte : apbI2cPkg::Stop;
							else if (loadTx)
							begin
								shiftReg <= txPopData;
								state    <= apbI2cPkg::WriteByte;
							end
							else
								state <= apbI2cPkg::Stop;
						end
					end
					apbI2cPkg::ReadByte:
					begin
						if (phase == '0)
							sdaLow <= 1'b0;
						if (phase == SampleAt)
							shiftReg <= {shiftReg[6:0], sdaIn};
						if (lastPhase)
						begin
							bitCnt <= bitCnt + 1'b1;
							if (lastBit)
							begin
								bytesLeft <= bytesLeft - 1'b1;
								state     <= apbI2cPkg::ReadAck;
							end
						end
					end
					apbI2cPkg::ReadAck:
					begin
						// ACK while bytes remain, NACK the last one
						if (phase == '0)
							sdaLow <= moreToRead;
						if (lastPhase)
							state <= moreToRead ? apbI2cPkg::ReadByte : apbI2cPkg::Stop;
					end
					apbI2cPkg::Stop:
					begin
						// Pull SDA low under SCL low, release it mid SCL high
						if (phase == '0)
							sdaLow <= 1'b1;
						if (phase == StopRise)
							sdaLow <= 1'b0;
						if (lastPhase)
							state <= apbI2cPkg::Idle;
					end
					default:
						state <= apbI2cPkg::Idle;
				endcase
			end
		end
	end

	// Only START and STOP move SDA while SCL is high
	assert property (@(posedge PCLK) disable iff (!PRESETn)
		$changed(sdaLow) |-> sclLow
			|| (state inside {apbI2cPkg::Start, apbI2cPkg::Stop}));

	// Nobody can hold SCL high against us, the bus resolves it low
	assert property (@(posedge PCLK) disable iff (!PRESETn)
		sclLow |-> !sclIn);

endmodule

`default_nettype wire

// File: source/syncFifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "apbI2c_defines.svh"

module syncFifo
#(
	parameter int Depth = `FifoDepth
)
(
	input  wire                     PCLK,
	input  wire                     PRESETn,
	// Write side
	input  wire                     pushValid,
	input  wire apbI2cPkg::dataByte pushData,
	output logic                    pushReady,
	// Read side
	input  wire                     popReady,
	output logic                    popValid,
	output apbI2cPkg::dataByte      popData,
	output logic                    empty
);

	localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CntW = $clog2(Depth + 1);
	localparam logic [PtrW-1:0] LastIdx = PtrW'(Depth - 1);
	localparam logic [CntW-1:0] FullCnt = CntW'(Depth);

	apbI2cPkg::dataByte mem [Depth];

	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [CntW-1:0] count;
	logic doPush;
	logic doPop;

	// Flags straight from the occupancy count
	assign pushReady = (count != FullCnt);
	assign popValid  = (count != '0);
	assign empty     = (count == '0);

	// Head of the queue is always presented
	assign popData = mem[rdPtr];

	assign doPush = pushValid && pushReady;
	assign doPop  = popValid && popReady;

	// Storage array
	always_ff @(posedge PCLK)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	// Pointers wrap at Depth, which need not be a power of two
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= (wrPtr == LastIdx) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == LastIdx) ? '0 : rdPtr + 1'b1;
			// Simultaneous push and pop leave the count alone
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

	assert property (@(posedge PCLK) disable iff (!PRESETn)
		count <= FullCnt);

endmodule

`default_nettype wire

// File: testbench/apbI2cTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "apbI2c_defines.svh"

module apbI2cTb;

	// Frames over all tests, each 9 bits
	localparam int TotalFrames = 27;
	localparam int CycleLimit  = TotalFrames * 9 * 2 * `SclHalf + 4000;
	localparam int PollLimit   = 400;

	logic PCLK;
	logic PRESETn;
	logic PSEL;
	logic PENABLE;
	logic PWRITE;
	apbI2cPkg::apbWord PADDR;
	apbI2cPkg::apbWord PWDATA;
	apbI2cPkg::apbWord PRDATA;
	logic PREADY;
	logic PSLVERR;
	logic intTx;
	logic intRx;
	logic dutSclLow;
	logic dutSdaLow;
	logic slaveSdaLow;
	logic scl;
	logic sda;
	logic byteValid;
	logic [7:0] byteData;

	int errorCount;
	int checkCount;
	int cycleCount;
	int stallCycles;
	logic [31:0] rdData;
	logic rdErr;
	logic [31:0] lcgState;
	logic [7:0] sentBytes [$];
	logic [7:0] gotBytes [$];

	// Open-drain resolution
	assign scl = !dutSclLow;
	assign sda = !(dutSdaLow || slaveSdaLow);

	tbClock clkGen (.PCLK(PCLK));

	apbI2cTop uut
	(
		.PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
		.PRDATA, .PREADY, .PSLVERR, .intTx, .intRx,
		.sclLow(dutSclLow), .sdaLow(dutSdaLow), .sclIn(scl), .sdaIn(sda)
	);

	i2cSlaveModel #(.Address(7'h2A)) slave
	(
		.PCLK, .PRESETn, .scl, .sda, .sdaLow(slaveSdaLow),
		.byteValid, .byteData
	);

	// Collect what the slave received
	always @(posedge PCLK)
	begin
		if (byteValid)
			gotBytes.push_back(byteData);
	end

	// Watchdog
	always @(posedge PCLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > CycleLimit)
		begin
			$display("Run stopped after %0d cycles, a transfer never ended", cycleCount);
			$display("Simulation FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcgStep(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("Fail at %0t: %s, got %h expected %h", $time, msg, actual, expected);
		end
	endtask

	// Setup phase, access phase, then hold until PREADY, counting stall cycles
	task automatic apbAccess(input logic wr, input logic [31:0] addr, input logic [31:0] data);
		stallCycles = 0;
		@(posedge PCLK);
		PSEL    <= 1'b1;
		PENABLE <= 1'b0;
		PWRITE  <= wr;
		PADDR   <= addr;
		PWDATA  <= data;
		@(posedge PCLK);
		PENABLE <= 1'b1;
		@(negedge PCLK);
		while (!PREADY)
		begin
			stallCycles++;
			@(negedge PCLK);
		end
		rdData = PRDATA;
		rdErr  = PSLVERR;
		@(posedge PCLK);
		PSEL    <= 1'b0;
		PENABLE <= 1'b0;
	endtask

	task automatic apbWrite(input logic [31:0] addr, input logic [31:0] data);
		apbAccess(1'b1, addr, data);
	endtask

	task automatic apbRead(input logic [31:0] addr);
		apbAccess(1'b0, addr, 32'h0);
	endtask

	// Poll the enable bit, which the master clears after STOP
	task automatic waitTransferDone();
		int polls;
		polls = 0;
		apbRead(`AddrConfig);
		while (rdData[8] && (polls < PollLimit))
		begin
			polls++;
			apbRead(`AddrConfig);
		end
		if (rdData[8])
		begin
			errorCount++;
			$display("Transfer still running after %0d polls", polls);
		end
	endtask

	task automatic pushBytes(input int n, input logic [7:0] first);
		for (int i = 0; i < n; i++)
		begin
			sentBytes.push_back(first + 8'(i * 37));
			apbWrite(`AddrTx, {24'h0, first + 8'(i * 37)});
		end
	endtask

	task automatic compareSent(input string msg);
		checkValue(gotBytes.size(), sentBytes.size(), {msg, " byte count"});
		for (int i = 0; i < sentBytes.size() && i < gotBytes.size(); i++)
			checkValue(gotBytes[i], sentBytes[i], {msg, " byte"});
	endtask

	//////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////

	task automatic resetValues();
		apbRead(`AddrConfig);
		checkValue(rdData, 0, "config after reset");
		checkValue(rdErr, 0, "PSLVERR after reset");
		apbRead(`AddrTimeout);
		checkValue(rdData, 0, "timeout after reset");
		checkValue(intTx, 1, "intTx after reset");
		checkValue(intRx, 0, "intRx after reset");
		apbWrite(`AddrTimeout, 32'hFFFF_ABCD);
		apbRead(`AddrTimeout);
		checkValue(rdData, 32'h0000_2BCD, "timeout readback");
		apbWrite(`AddrTimeout, 0);
	endtask

	task automatic writeTransfer();
		sentBytes.delete();
		gotBytes.delete();
		pushBytes(3, 8'hA5);
		apbWrite(`AddrConfig, 32'h12A);
		waitTransferDone();
		checkValue(rdErr, 0, "error after write transfer");
		compareSent("write transfer");
	endtask

	task automatic readTransfer();
		logic [31:0] expected;
		apbWrite(`AddrConfig, (4 << 9) | 32'h100 | 32'h80 | 32'h2A);
		waitTransferDone();
		checkValue(intRx, 1, "intRx after read transfer");
		for (int i = 0; i < 4; i++)
		begin
			lcgState = lcgStep(lcgState);
			expected = {24'h0, lcgState[23:16]};
			apbRead(`AddrRx);
			checkValue(rdData, expected, "read data");
			checkValue(rdErr, 0, "PSLVERR on read data");
		end
		apbRead(`AddrRx);
		checkValue(rdErr, 1, "PSLVERR on empty RX read");
		checkValue(rdData, 0, "data on empty RX read");
	endtask

	task automatic nackTransfer();
		sentBytes.delete();
		gotBytes.delete();
		pushBytes(2, 8'h11);
		apbWrite(`AddrConfig, 32'h111);
		waitTransferDone();
		apbRead(`AddrTimeout);
		checkValue(rdErr, 1, "PSLVERR after NACK");
		checkValue(intTx, 0, "TX bytes kept after NACK");
		apbWrite(`AddrConfig, 0);
		apbRead(`AddrTimeout);
		checkValue(rdErr, 0, "PSLVERR after config write");
	endtask

	task automatic timeoutTransfer();
		apbWrite(`AddrTimeout, 1);
		pushBytes(3, 8'h40);
		apbWrite(`AddrConfig, 32'h12A);
		waitTransferDone();
		apbRead(`AddrTimeout);
		checkValue(rdErr, 1, "PSLVERR after timeout");
		apbWrite(`AddrConfig, 0);
		apbWrite(`AddrTimeout, 0);
		// Drain what the aborted transfers left behind, every byte still in push order
		gotBytes.delete();
		apbWrite(`AddrConfig, 32'h12A);
		waitTransferDone();
		checkValue(intTx, 1, "TX FIFO drained");
		compareSent("bytes kept by NACK and timeout");
	endtask

	task automatic backPressure();
		sentBytes.delete();
		gotBytes.delete();
		// Master waits in Idle for the first byte
		apbWrite(`AddrConfig, 32'h12A);
		pushBytes(`FifoDepth, 8'h07);
		sentBytes.push_back(8'hEE);
		apbWrite(`AddrTx, 32'hEE);
		if (stallCycles == 0)
		begin
			errorCount++;
			$display("Push into a full TX FIFO completed without a wait state");
		end
		waitTransferDone();
		checkValue(rdErr, 0, "error after back-pressure transfer");
		compareSent("back-pressure");
	endtask

	initial
	begin
		PRESETn  <= 1'b0;
		PSEL     <= 1'b0;
		PENABLE  <= 1'b0;
		PWRITE   <= 1'b0;
		PADDR    <= '0;
		PWDATA   <= '0;
		errorCount = 0;
		checkCount = 0;
		lcgState   = 32'd58;
		repeat (10) @(posedge PCLK);
		PRESETn <= 1'b1;
		resetValues();
		writeTransfer();
		readTransfer();
		nackTransfer();
		timeoutTransfer();
		backPressure();
		repeat (5) @(posedge PCLK);
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/i2cSlaveModel.sv
`timescale 1ns/10ps
`default_nettype none

module i2cSlaveModel
#(
	parameter logic [6:0] Address = 7'h2A
)
(
	input  wire        PCLK,
	input  wire        PRESETn,
	// Resolved bus lines
	input  wire        scl,
	input  wire        sda,
	output logic       sdaLow,
	// One pulse per byte written by the master
	output logic       byteValid,
	output logic [7:0] byteData
);

	localparam int ModeIdle  = 0;
	localparam int ModeAddr  = 1;
	localparam int ModeWrite = 2;
	localparam int ModeRead  = 3;

	int          mode;
	logic [3:0]  bitCnt;
	logic [7:0]  shiftIn;
	logic [7:0]  txByte;
	logic        inAck;
	logic        masterAck;
	logic        sclPrev;
	logic        sdaPrev;
	logic [31:0] lcgState;
	logic [31:0] nextLcg;

	// Read data generator, seeded with 58
	function automatic logic [31:0] lcgStep(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	always @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			mode      <= ModeIdle;
			bitCnt    <= '0;
			shiftIn   <= '0;
			txByte    <= '0;
			inAck     <= 1'b0;
			masterAck <= 1'b0;
			sclPrev   <= 1'b1;
			sdaPrev   <= 1'b1;
			sdaLow    <= 1'b0;
			byteValid <= 1'b0;
			byteData  <= '0;
			lcgState  <= 32'd58;
		end
		else
		begin
			nextLcg = lcgStep(lcgState);
			sclPrev   <= scl;
			sdaPrev   <= sda;
			byteValid <= 1'b0;
			// START: SDA falls with SCL high
			if (scl && sclPrev && sdaPrev && !sda)
			begin
				mode   <= ModeAddr;
				bitCnt <= '0;
				inAck  <= 1'b0;
				sdaLow <= 1'b0;
			end
			// STOP: SDA rises with SCL high
			else if (scl && sclPrev && !sdaPrev && sda)
			begin
				mode   <= ModeIdle;
				inAck  <= 1'b0;
				sdaLow <= 1'b0;
			end
			else if (scl && !sclPrev)
			begin
				if (inAck)
					masterAck <= !sda;
				else if ((bitCnt < 4'd8) && (mode != ModeIdle))
				begin
					if (mode != ModeRead)
						shiftIn <= {shiftIn[6:0], sda};
					bitCnt <= bitCnt + 1'b1;
				end
			end
			else if (!scl && sclPrev)
			begin
				if ((mode == ModeAddr) || (mode == ModeWrite))
				begin
					if (!inAck && (bitCnt == 4'd8))
					begin
						if (mode == ModeWrite)
						begin
							inAck     <= 1'b1;
							sdaLow    <= 1'b1;
							byteValid <= 1'b1;
							byteData  <= shiftIn;
						end
						else if (shiftIn[7:1] == Address)
						begin
							inAck  <= 1'b1;
							sdaLow <= 1'b1;
						end
						else
							mode <= ModeIdle;
					end
					else if (inAck)
					begin
						// End of the ack slot
						inAck  <= 1'b0;
						bitCnt <= '0;
						sdaLow <= 1'b0;
						if ((mode == ModeAddr) && shiftIn[0])
						begin
							mode     <= ModeRead;
							lcgState <= nextLcg;
							txByte   <= nextLcg[23:16];
							sdaLow   <= !nextLcg[23];
						end
						else if (mode == ModeAddr)
							mode <= ModeWrite;
					end
				end
				else if (mode == ModeRead)
				begin
					if (inAck)
					begin
						inAck  <= 1'b0;
						bitCnt <= '0;
						if (masterAck)
						begin
							lcgState <= nextLcg;
							txByte   <= nextLcg[23:16];
							sdaLow   <= !nextLcg[23];
						end
						else
						begin
							mode   <= ModeIdle;
							sdaLow <= 1'b0;
						end
					end
					else if (bitCnt == 4'd8)
					begin
						// Hand SDA to the master for its ACK
						inAck  <= 1'b1;
						sdaLow <= 1'b0;
					end
					else if (bitCnt != 4'd0)
						sdaLow <= !txByte[3'd7 - bitCnt[2:0]];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/tbClock.sv
`timescale 1ns/10ps
`default_nettype none

module tbClock
#(
	parameter int PeriodNs = 10
)
(
	output logic PCLK
);

	// Free-running clock, starts low
	initial
	begin
		PCLK = 1'b0;
	end

	always #(PeriodNs / 2) PCLK = ~PCLK;

endmodule

`default_nettype wire
